/* source/socPkg.sv */
package socPkg;

    // host bus geometry
    localparam int DATA_WIDTH = 32;
    localparam int ADDR_WIDTH = 32;
    localparam int BYTE_LANES = 4;

    // 4-bit region field starts here
    localparam int REGION_LSB = 16;
    localparam logic [3:0] REGION_RAM    = 4'd0;
    localparam logic [3:0] REGION_TIMER  = 4'd1;
    localparam logic [3:0] REGION_RANDOM = 4'd2;
    localparam logic [3:0] REGION_IRQ    = 4'd3;

    // local word address widths of the register blocks
    // timer has 2 offset bits plus 2 select bits, enough for four timers
    localparam int TIMER_ADDR_WIDTH = 4;
    localparam int IRQ_ADDR_WIDTH   = 2;

    // word offsets inside one timer block
    localparam logic [1:0] TIMER_REG_PERIOD  = 2'd0;
    localparam logic [1:0] TIMER_REG_CONTROL = 2'd1;
    localparam logic [1:0] TIMER_REG_COUNT   = 2'd2;
    localparam int TIMER_CTRL_ENABLE = 0;
    localparam int TIMER_CTRL_RELOAD = 1;

    // interrupt controller word offsets
    localparam logic [1:0] IRQ_REG_PENDING = 2'd0;
    localparam logic [1:0] IRQ_REG_ENABLE  = 2'd1;
    localparam logic [1:0] IRQ_REG_HIGHEST = 2'd2;

    // galois feedback and seed
    localparam logic [DATA_WIDTH-1:0] LFSR_TAPS       = 32'h8020_0003;
    localparam logic [DATA_WIDTH-1:0] LFSR_RESET_SEED = 32'hACE1_ACE1;
    localparam logic [DATA_WIDTH-1:0] NO_IRQ_CODE     = 32'hFFFF_FFFF;

    // one bus word, whole or per byte lane
    typedef union packed {
        logic [DATA_WIDTH-1:0]      word;
        logic [BYTE_LANES-1:0][7:0] lane;
    } busWord_u;

endpackage

/* source/busInterconnect.sv */
`timescale 1ns/1ps

module busInterconnect #(
    parameter int RAM_WORDS   = 1024,
    parameter int TIMER_COUNT = 3
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 read,
    input  logic                                 write,
    input  logic [socPkg::ADDR_WIDTH-1:0]        address,
    input  logic                                 ramValid,
    input  logic [socPkg::DATA_WIDTH-1:0]        ramData,
    input  logic                                 timerValid,
    input  logic [socPkg::DATA_WIDTH-1:0]        timerData,
    input  logic                                 randomValid,
    input  logic [socPkg::DATA_WIDTH-1:0]        randomData,
    input  logic                                 irqValid,
    input  logic [socPkg::DATA_WIDTH-1:0]        irqData,
    output logic                                 ramRead,
    output logic                                 ramWrite,
    output logic [$clog2(RAM_WORDS)-1:0]         ramAddress,
    output logic                                 timerRead,
    output logic                                 timerWrite,
    output logic [socPkg::TIMER_ADDR_WIDTH-1:0]  timerAddress,
    output logic                                 randomRead,
    output logic                                 randomWrite,
    output logic                                 irqRead,
    output logic                                 irqWrite,
    output logic [socPkg::IRQ_ADDR_WIDTH-1:0]    irqAddress,
    output logic                                 readValid,
    output logic [socPkg::DATA_WIDTH-1:0]        readData
);
    import socPkg::*;

    logic [3:0] region;
    logic       ramHit;
    logic       timerHit;
    logic       randomHit;
    logic       irqHit;
    logic       unmappedValid;

    // region field picks the peripheral
    assign region    = address[REGION_LSB +: 4];
    assign ramHit    = region == REGION_RAM;
    // timer blocks past the last timer are unmapped
    assign timerHit  = (region == REGION_TIMER) &&
                       (32'(address[REGION_LSB-1:4]) < TIMER_COUNT);
    assign randomHit = region == REGION_RANDOM;
    assign irqHit    = region == REGION_IRQ;

    // per-peripheral strobes
    assign ramRead     = read && ramHit;
    assign ramWrite    = write && ramHit;
    assign timerRead   = read && timerHit;
    assign timerWrite  = write && timerHit;
    assign randomRead  = read && randomHit;
    assign randomWrite = write && randomHit;
    assign irqRead     = read && irqHit;
    assign irqWrite    = write && irqHit;

    // local word addresses, byte offset dropped
    assign ramAddress   = address[2 +: $clog2(RAM_WORDS)];
    assign timerAddress = address[2 +: TIMER_ADDR_WIDTH];
    assign irqAddress   = address[2 +: IRQ_ADDR_WIDTH];

    // zero answer for unmapped reads, same latency as a peripheral
    always_ff @(posedge clk) begin
        if (rst) begin
            unmappedValid <= 1'b0;
        end else begin
            unmappedValid <= read && !(ramHit || timerHit || randomHit || irqHit);
        end
    end

    assign readValid = ramValid || timerValid || randomValid || irqValid || unmappedValid;

    // only one responder per cycle
    always_comb begin
        if (ramValid) begin
            readData = ramData;
        end else if (timerValid) begin
            readData = timerData;
        end else if (randomValid) begin
            readData = randomData;
        end else if (irqValid) begin
            readData = irqData;
        end else begin
            // unmapped or idle
            readData = '0;
        end
    end

endmodule

/* source/scratchRam.sv */
`timescale 1ns/1ps

module scratchRam #(
    parameter int RAM_WORDS = 1024
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           read,
    input  logic                           write,
    input  logic [$clog2(RAM_WORDS)-1:0]   address,
    input  logic [socPkg::BYTE_LANES-1:0]  bwe,
    input  logic [socPkg::DATA_WIDTH-1:0]  writeData,
    output logic                           readValid,
    output socPkg::busWord_u               readData
);
    import socPkg::*;

    busWord_u mem [RAM_WORDS];
    busWord_u writeWord;

    // byte view of the incoming word
    assign writeWord = writeData;

    // lane merge on write
    always_ff @(posedge clk) begin
        if (write) begin
            for (int b = 0; b < BYTE_LANES; b++) begin
                if (bwe[b]) begin
                    mem[address].lane[b] <= writeWord.lane[b];
                end
            end
        end
    end

    // registered read port
    always_ff @(posedge clk) begin
        if (read) begin
            readData <= mem[address];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            readValid <= 1'b0;
        end else begin
            readValid <= read;
        end
    end

endmodule

/* source/intervalTimer.sv */
`timescale 1ns/1ps

module intervalTimer #(
    parameter int TIMER_COUNT = 3
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 read,
    input  logic                                 write,
    input  logic [socPkg::TIMER_ADDR_WIDTH-1:0]  address,
    input  logic [socPkg::DATA_WIDTH-1:0]        writeData,
    output logic                                 readValid,
    output logic [socPkg::DATA_WIDTH-1:0]        readData,
    output logic [TIMER_COUNT-1:0]               expiry
);
    import socPkg::*;

    logic [DATA_WIDTH-1:0] period  [TIMER_COUNT];
    logic [DATA_WIDTH-1:0] count   [TIMER_COUNT];
    logic [1:0]            control [TIMER_COUNT];
    logic [1:0]            select;
    logic [1:0]            offset;
    logic [DATA_WIDTH-1:0] readWord;

    // upper bits pick the timer, lower bits the register
    assign select = address[3:2];
    assign offset = address[1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < TIMER_COUNT; i++) begin
                period[i]  <= '0;
                count[i]   <= '0;
                control[i] <= '0;
            end
            expiry <= '0;
        end else begin
            for (int i = 0; i < TIMER_COUNT; i++) begin
                expiry[i] <= 1'b0;
                if (write && int'(select) == i) begin
                    // host write wins over counting
                    case (offset)
                        TIMER_REG_PERIOD: begin
                            period[i] <= writeData;
                            count[i]  <= writeData;
                        end
                        TIMER_REG_CONTROL: control[i] <= writeData[1:0];
                        TIMER_REG_COUNT: count[i] <= writeData;
                        default: ;
                    endcase
                end else if (control[i][TIMER_CTRL_ENABLE]) begin
                    if (count[i] == '0) begin
                        // reload one edge after reaching zero
                        if (control[i][TIMER_CTRL_RELOAD]) begin
                            count[i] <= period[i];
                        end else begin
                            control[i][TIMER_CTRL_ENABLE] <= 1'b0;
                        end
                    end else begin
                        count[i] <= count[i] - 1'b1;
                        if (count[i] == 1) begin
                            expiry[i] <= 1'b1;
                            // one-shot stops as it hits zero
                            if (!control[i][TIMER_CTRL_RELOAD]) begin
                                control[i][TIMER_CTRL_ENABLE] <= 1'b0;
                            end
                        end
                    end
                end
            end
        end
    end

    // register read mux
    always_comb begin
        readWord = '0;
        for (int i = 0; i < TIMER_COUNT; i++) begin
            if (int'(select) == i) begin
                case (offset)
                    TIMER_REG_PERIOD: readWord = period[i];
                    TIMER_REG_CONTROL: readWord = {{(DATA_WIDTH-2){1'b0}}, control[i]};
                    TIMER_REG_COUNT: readWord = count[i];
                    default: readWord = '0;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (read) begin
            readData <= readWord;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            readValid <= 1'b0;
        end else begin
            readValid <= read;
        end
    end

endmodule

/* source/randomSource.sv */
`timescale 1ns/1ps

module randomSource (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           read,
    input  logic                           write,
    input  logic [socPkg::DATA_WIDTH-1:0]  writeData,
    output logic                           readValid,
    output logic [socPkg::DATA_WIDTH-1:0]  readData
);
    import socPkg::*;

    logic [DATA_WIDTH-1:0] state;
    logic [DATA_WIDTH-1:0] nextState;

    // galois step, taps folded in when a one drops out
    assign nextState = {1'b0, state[DATA_WIDTH-1:1]} ^ (state[0] ? LFSR_TAPS : '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= LFSR_RESET_SEED;
            readValid <= 1'b0;
        end else begin
            readValid <= read;
            if (write) begin
                // zero would lock the register
                state <= (writeData == '0) ? LFSR_RESET_SEED : writeData;
            end else if (read) begin
                state <= nextState;
            end
        end
    end

    // current state goes out, step happens alongside
    always_ff @(posedge clk) begin
        if (read) begin
            readData <= state;
        end
    end

endmodule

/* source/interruptController.sv */
`timescale 1ns/1ps

module interruptController #(
    parameter int TIMER_COUNT = 3
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               read,
    input  logic                               write,
    input  logic [socPkg::IRQ_ADDR_WIDTH-1:0]  address,
    input  logic [socPkg::DATA_WIDTH-1:0]      writeData,
    input  logic [TIMER_COUNT-1:0]             expiry,
    output logic                               readValid,
    output logic [socPkg::DATA_WIDTH-1:0]      readData,
    output logic                               interruptRequest
);
    import socPkg::*;

    logic [TIMER_COUNT-1:0] pending;
    logic [TIMER_COUNT-1:0] enable;
    logic [TIMER_COUNT-1:0] active;
    logic [TIMER_COUNT-1:0] clearMask;
    logic [DATA_WIDTH-1:0]  highest;
    logic [DATA_WIDTH-1:0]  readWord;

    assign active = pending & enable;

    // write-one-to-clear on the pending register
    assign clearMask = (write && address == IRQ_REG_PENDING) ? writeData[TIMER_COUNT-1:0] : '0;

    // lowest pending source has priority
    always_comb begin
        highest = NO_IRQ_CODE;
        for (int i = TIMER_COUNT - 1; i >= 0; i--) begin
            if (active[i]) begin
                highest = DATA_WIDTH'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pending          <= '0;
            enable           <= '0;
            interruptRequest <= 1'b0;
            readValid        <= 1'b0;
        end else begin
            // a new expiry beats a clear in the same cycle
            pending <= (pending & ~clearMask) | expiry;
            if (write && address == IRQ_REG_ENABLE) begin
                enable <= writeData[TIMER_COUNT-1:0];
            end
            interruptRequest <= |active;
            readValid        <= read;
        end
    end

    always_comb begin
        case (address)
            IRQ_REG_PENDING: readWord = DATA_WIDTH'(pending);
            IRQ_REG_ENABLE: readWord = DATA_WIDTH'(enable);
            IRQ_REG_HIGHEST: readWord = highest;
            default: readWord = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (read) begin
            readData <= readWord;
        end
    end

endmodule

/* source/peripheralSoc.sv */
`timescale 1ns/1ps

module peripheralSoc #(
    parameter int RAM_WORDS   = 1024,
    parameter int TIMER_COUNT = 3
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           read,
    input  logic                           write,
    input  logic [socPkg::ADDR_WIDTH-1:0]  address,
    input  logic [socPkg::BYTE_LANES-1:0]  bwe,
    input  logic [socPkg::DATA_WIDTH-1:0]  writeData,
    output logic                           readValid,
    output logic [socPkg::DATA_WIDTH-1:0]  readData,
    output logic                           interruptRequest
);
    import socPkg::*;

    // ram side
    logic                          ramRead;
    logic                          ramWrite;
    logic [$clog2(RAM_WORDS)-1:0]  ramAddress;
    logic                          ramValid;
    busWord_u                      ramData;

    // timer side
    logic                          timerRead;
    logic                          timerWrite;
    logic [TIMER_ADDR_WIDTH-1:0]   timerAddress;
    logic                          timerValid;
    logic [DATA_WIDTH-1:0]         timerData;
    logic [TIMER_COUNT-1:0]        expiry;

    // random source side
    logic                          randomRead;
    logic                          randomWrite;
    logic                          randomValid;
    logic [DATA_WIDTH-1:0]         randomData;

    // interrupt controller side
    logic                          irqRead;
    logic                          irqWrite;
    logic [IRQ_ADDR_WIDTH-1:0]     irqAddress;
    logic                          irqValid;
    logic [DATA_WIDTH-1:0]         irqData;

    busInterconnect #(.RAM_WORDS(RAM_WORDS), .TIMER_COUNT(TIMER_COUNT))
    busInterconnect(
        .clk, .rst, .read, .write, .address,
        .ramValid, .ramData, .timerValid, .timerData,
        .randomValid, .randomData, .irqValid, .irqData,
        .ramRead, .ramWrite, .ramAddress,
        .timerRead, .timerWrite, .timerAddress,
        .randomRead, .randomWrite,
        .irqRead, .irqWrite, .irqAddress,
        .readValid, .readData
    );

    scratchRam #(.RAM_WORDS(RAM_WORDS))
    scratchRam(
        .clk, .rst,
        .read           (ramRead),
        .write          (ramWrite),
        .address        (ramAddress),
        .bwe, .writeData,
        .readValid      (ramValid),
        .readData       (ramData)
    );

    intervalTimer #(.TIMER_COUNT(TIMER_COUNT))
    intervalTimer(
        .clk, .rst,
        .read           (timerRead),
        .write          (timerWrite),
        .address        (timerAddress),
        .writeData,
        .readValid      (timerValid),
        .readData       (timerData),
        .expiry
    );

    randomSource
    randomSource(
        .clk, .rst,
        .read           (randomRead),
        .write          (randomWrite),
        .writeData,
        .readValid      (randomValid),
        .readData       (randomData)
    );

    // timer expiries are the only interrupt sources
    interruptController #(.TIMER_COUNT(TIMER_COUNT))
    interruptController(
        .clk, .rst,
        .read           (irqRead),
        .write          (irqWrite),
        .address        (irqAddress),
        .writeData,
        .expiry,
        .readValid      (irqValid),
        .readData       (irqData),
        .interruptRequest
    );

endmodule

/* dv/tbClock.sv */
`timescale 1ns/1ps

module tbClock #(
    parameter int PERIOD       = 8,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst
);

    // free-running clock
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // reset held for a fixed number of edges, released just after an edge
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

/* dv/socTb.sv */
`timescale 1ns/1ps

module socTb;
    import socPkg::*;

    localparam int RAM_WORDS   = 1024;
    localparam int TIMER_COUNT = 3;
    localparam int CLK_PERIOD  = 8;
    localparam int TEST_WORDS  = 8;
    // worst-case cycles of the ram, pipeline, random, one-shot and auto-reload tests
    localparam int BUDGET_CYCLES = 400 + 200 + 200 + 500 + 1200;

    logic                  clk;
    logic                  rst;
    logic                  read;
    logic                  write;
    logic [ADDR_WIDTH-1:0] address;
    logic [BYTE_LANES-1:0] bwe;
    logic [DATA_WIDTH-1:0] writeData;
    logic                  readValid;
    logic [DATA_WIDTH-1:0] readData;
    logic                  interruptRequest;

    int       mismatchCount = 0;
    int       timeoutCount  = 0;
    // expected ram contents for the first two tests
    busWord_u shadow [TEST_WORDS];

    tbClock #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(8)) clockGen(.clk, .rst);

    peripheralSoc #(.RAM_WORDS(RAM_WORDS), .TIMER_COUNT(TIMER_COUNT)) dut_i(
        .clk, .rst, .read, .write, .address, .bwe, .writeData,
        .readValid, .readData, .interruptRequest
    );

    // byte address of a word inside a region
    function automatic logic [ADDR_WIDTH-1:0] regionAddr(input logic [3:0] region, input int word);
        return (ADDR_WIDTH'(region) << REGION_LSB) | ADDR_WIDTH'(word * 4);
    endfunction

    // scattered ram words
    function automatic logic [ADDR_WIDTH-1:0] ramAddr(input int index);
        return regionAddr(REGION_RAM, (index * 131 + 5) % RAM_WORDS);
    endfunction

    // four words per timer block
    function automatic logic [ADDR_WIDTH-1:0] timerReg(input int timer, input logic [1:0] offset);
        return regionAddr(REGION_TIMER, timer * 4 + int'(offset));
    endfunction

    function automatic logic [ADDR_WIDTH-1:0] irqReg(input logic [1:0] offset);
        return regionAddr(REGION_IRQ, int'(offset));
    endfunction

    // galois model shifts right and folds the taps back in when a one drops out
    function automatic logic [DATA_WIDTH-1:0] lfsrNext(input logic [DATA_WIDTH-1:0] s);
        if (s[0]) begin
            return (s >> 1) ^ LFSR_TAPS;
        end
        return s >> 1;
    endfunction

    task automatic checkWord(input busWord_u got, input busWord_u expected, input string what);
        if (got.word !== expected.word) begin
            mismatchCount++;
            $display("Fail at %0d ns: %s read %h, expected %h", $time, what, got.word,
                     expected.word);
        end
    endtask

    task automatic checkBit(input logic got, input logic expected, input string what);
        if (got !== expected) begin
            mismatchCount++;
            $display("Fail at %0d ns: %s is %b, expected %b", $time, what, got, expected);
        end
    endtask

    // one write strobe driven just after the edge
    task automatic busWrite(input logic [ADDR_WIDTH-1:0] addr, input logic [DATA_WIDTH-1:0] data,
                            input logic [BYTE_LANES-1:0] lanes);
        @(posedge clk);
        #1;
        write     = 1'b1;
        address   = addr;
        writeData = data;
        bwe       = lanes;
        @(posedge clk);
        #1;
        write = 1'b0;
        bwe   = '0;
    endtask

    task automatic busRead(input logic [ADDR_WIDTH-1:0] addr, output logic [DATA_WIDTH-1:0] data);
        @(posedge clk);
        #1;
        read    = 1'b1;
        address = addr;
        @(posedge clk);
        #1;
        read = 1'b0;
        // answer comes back after the strobe edge
        while (!readValid) begin
            @(posedge clk);
            #1;
        end
        data = readData;
    endtask

    task automatic ramByteLanes();
        busWord_u              data;
        logic [DATA_WIDTH-1:0] value;
        logic [BYTE_LANES-1:0] lanes;
        for (int i = 0; i < TEST_WORDS; i++) begin
            shadow[i].word = $urandom();
            busWrite(ramAddr(i), shadow[i].word, '1);
        end
        // one byte per word merged into the shadow lane by lane
        for (int i = 0; i < TEST_WORDS; i++) begin
            data.word = $urandom();
            lanes     = BYTE_LANES'(1) << $urandom_range(BYTE_LANES - 1);
            busWrite(ramAddr(i), data.word, lanes);
            for (int b = 0; b < BYTE_LANES; b++) begin
                if (lanes[b]) begin
                    shadow[i].lane[b] = data.lane[b];
                end
            end
        end
        for (int i = 0; i < TEST_WORDS; i++) begin
            busRead(ramAddr(i), value);
            checkWord(value, shadow[i], $sformatf("ram word %0d", i));
        end
    endtask

    task automatic pipelinedReads();
        logic [ADDR_WIDTH-1:0] addrs [TEST_WORDS];
        busWord_u              expected [TEST_WORDS];
        for (int i = 0; i < TEST_WORDS; i++) begin
            if (i % 2 == 0) begin
                addrs[i]    = ramAddr(i);
                expected[i] = shadow[i];
            end else begin
                // regions 4 to 15 decode to nothing
                addrs[i]         = regionAddr(4'(4 + $urandom_range(11)), i);
                expected[i].word = '0;
            end
        end
        @(posedge clk);
        #1;
        read    = 1'b1;
        address = addrs[0];
        // a new strobe every cycle while the previous answer is checked
        for (int i = 1; i <= TEST_WORDS; i++) begin
            @(posedge clk);
            #1;
            checkBit(readValid, 1'b1, $sformatf("readValid of pipelined read %0d", i - 1));
            checkWord(readData, expected[i - 1], $sformatf("pipelined read %0d", i - 1));
            if (i < TEST_WORDS) begin
                address = addrs[i];
            end else begin
                read = 1'b0;
            end
        end
        @(posedge clk);
        #1;
        checkBit(readValid, 1'b0, "readValid after the last pipelined read");
    endtask

    // several draws against the model
    task automatic checkRandomRun(input logic [DATA_WIDTH-1:0] start, input string label);
        logic [DATA_WIDTH-1:0] model;
        logic [DATA_WIDTH-1:0] value;
        model = start;
        for (int i = 0; i < 6; i++) begin
            busRead(regionAddr(REGION_RANDOM, 0), value);
            checkWord(value, model, $sformatf("%s, draw %0d", label, i));
            model = lfsrNext(model);
        end
    endtask

    task automatic randomSequence();
        logic [DATA_WIDTH-1:0] seed;
        checkRandomRun(LFSR_RESET_SEED, "random after reset");
        seed = $urandom();
        if (seed == '0) begin
            seed = 32'h1;
        end
        busWrite(regionAddr(REGION_RANDOM, 0), seed, '1);
        checkRandomRun(seed, "random after seed");
        // zero seed falls back to the reset seed
        busWrite(regionAddr(REGION_RANDOM, 0), '0, '1);
        checkRandomRun(LFSR_RESET_SEED, "random after zero seed");
    endtask

    task automatic oneShotTimer();
        logic [DATA_WIDTH-1:0] value;
        busWrite(timerReg(0, TIMER_REG_PERIOD), 32'd20, '1);
        busWrite(timerReg(0, TIMER_REG_CONTROL), 32'(1 << TIMER_CTRL_ENABLE), '1);
        value = '1;
        while (value != '0) begin
            busRead(timerReg(0, TIMER_REG_COUNT), value);
        end
        busRead(timerReg(0, TIMER_REG_CONTROL), value);
        checkWord(value, '0, "timer 0 control after one-shot");
        busRead(irqReg(IRQ_REG_PENDING), value);
        checkWord(value, 32'h1, "pending after one-shot");
        // masked source raises no request
        checkBit(interruptRequest, 1'b0, "interruptRequest before enable");
        busWrite(irqReg(IRQ_REG_ENABLE), 32'h1, '1);
        @(posedge clk);
        #1;
        checkBit(interruptRequest, 1'b1, "interruptRequest after enable");
        busWrite(irqReg(IRQ_REG_PENDING), 32'h1, '1);
        @(posedge clk);
        #1;
        checkBit(interruptRequest, 1'b0, "interruptRequest after clear");
    endtask

    task automatic autoReloadPriority();
        logic [DATA_WIDTH-1:0] value;
        logic [DATA_WIDTH-1:0] both;
        logic [DATA_WIDTH-1:0] runBits;
        both    = 32'b110;
        runBits = 32'((1 << TIMER_CTRL_ENABLE) | (1 << TIMER_CTRL_RELOAD));
        // long period on timer 2 leaves room for the clear sequence
        busWrite(timerReg(1, TIMER_REG_PERIOD), 32'd60, '1);
        busWrite(timerReg(2, TIMER_REG_PERIOD), 32'd200, '1);
        busWrite(irqReg(IRQ_REG_ENABLE), both, '1);
        busWrite(timerReg(1, TIMER_REG_CONTROL), runBits, '1);
        busWrite(timerReg(2, TIMER_REG_CONTROL), runBits, '1);
        value = '0;
        while ((value & both) != both) begin
            busRead(irqReg(IRQ_REG_PENDING), value);
        end
        checkBit(interruptRequest, 1'b1, "interruptRequest with both sources pending");
        busRead(irqReg(IRQ_REG_HIGHEST), value);
        checkWord(value, 32'd1, "highest source with 1 and 2 pending");
        // timer 1 stopped so its reload cannot refill bit 1
        busWrite(timerReg(1, TIMER_REG_CONTROL), '0, '1);
        busWrite(irqReg(IRQ_REG_PENDING), 32'b010, '1);
        busRead(irqReg(IRQ_REG_HIGHEST), value);
        checkWord(value, 32'd2, "highest source after clearing 1");
        busWrite(irqReg(IRQ_REG_PENDING), 32'b100, '1);
        busRead(irqReg(IRQ_REG_HIGHEST), value);
        checkWord(value, NO_IRQ_CODE, "highest source with nothing pending");
        checkBit(interruptRequest, 1'b0, "interruptRequest after clearing all");
        busRead(timerReg(2, TIMER_REG_CONTROL), value);
        checkWord(value, runBits, "timer 2 control while reloading");
    endtask

    initial begin
        void'($urandom(53));
        read      = 1'b0;
        write     = 1'b0;
        address   = '0;
        bwe       = '0;
        writeData = '0;
        @(negedge rst);
        @(posedge clk);
        ramByteLanes();
        pipelinedReads();
        randomSequence();
        oneShotTimer();
        autoReloadPriority();
        $display("errors: %0d mismatches, %0d timeouts", mismatchCount, timeoutCount);
        if (mismatchCount == 0 && timeoutCount == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // twice the summed worst case
    initial begin
        #(2 * BUDGET_CYCLES * CLK_PERIOD);
        timeoutCount++;
        $display("Timeout: the tests did not finish within %0d cycles", 2 * BUDGET_CYCLES);
        $display("errors: %0d mismatches, %0d timeouts", mismatchCount, timeoutCount);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

/* flist.f */
source/socPkg.sv
source/busInterconnect.sv
source/scratchRam.sv
source/intervalTimer.sv
source/randomSource.sv
source/interruptController.sv
source/peripheralSoc.sv
dv/tbClock.sv
dv/socTb.sv

/* Makefile */
# Verilator build and run of the peripheral subsystem testbench

VERILATOR ?= verilator
TOP       ?= socTb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal -j 0
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o V$(TOP)

# pass only when the log holds the pass line
run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
